// ==== src.f ====
+incdir+verif
hdl/gb80_pkg.sv
hdl/alu_if.sv
hdl/gb80_alu.sv
hdl/alu_seq.sv
hdl/alu_regs.sv
hdl/gb80_alu_top.sv
verif/tb_gb80_alu_top.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_gb80_alu_top -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_gb80_alu_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
   exit 0
fi
exit 1

// ==== verif/tb_alu_model.svh ====
// Expected {flags, result} per request, Game Boy ZNHC rules
// x is the primary operand (OPA), y the secondary (OPB)
function automatic logic [11:0] model_byte(alu_op_e op, alu_size_e size, logic [7:0] x,
                                           logic [7:0] y, logic [3:0] fin);
   logic [7:0] r;
   logic [3:0] f;
   logic       zres;
   int         c;
   int         t;
   r    = y;
   f    = 4'd0;
   zres = 1'b1;   // Z follows the result unless cleared below
   c    = (op == ALU_ADC || op == ALU_SBC) ? int'(fin[F_C]) : 0;
   case (op)
      ALU_ADD, ALU_ADC: begin
         t = int'(x) + int'(y) + c;
         r = 8'(t);
         f[F_H] = int'(x[3:0]) + int'(y[3:0]) + c > 15;
         f[F_C] = t > 255;
         zres = (size != ALU_SIZE_SPEC);
      end
      ALU_SUB, ALU_SBC: begin
         t = int'(x) - int'(y) - c;
         r = 8'(t);
         f[F_N] = 1'b1;
         f[F_H] = int'(x[3:0]) < int'(y[3:0]) + c;   // Nibble borrow
         f[F_C] = t < 0;
      end
      ALU_AND: begin
         r = x & y;
         f[F_H] = 1'b1;
      end
      ALU_OR:  r = x | y;
      ALU_XOR: r = x ^ y;
      ALU_INC, ALU_DEC: begin
         r = (op == ALU_INC) ? x + 8'd1 : x - 8'd1;
         f[F_N] = (op == ALU_DEC);
         f[F_H] = (op == ALU_INC) ? (x[3:0] == 4'hf) : (x[3:0] == 4'h0);
         f[F_C] = fin[F_C];
      end
      ALU_DAA: begin
         t = int'(x);
         if (!fin[F_N]) begin
            if (fin[F_H] || x[3:0] > 4'h9) t = t + 6;
            if (fin[F_C] || t > 'h9f) t = t + 'h60;
         end else begin
            if (fin[F_H]) t = (t - 6) & 'hff;
            if (fin[F_C]) t = t - 'h60;
         end
         r = 8'(t);
         f[F_N] = fin[F_N];
         f[F_C] = fin[F_C] || t > 255;
      end
      ALU_NOT: begin
         r = ~x;
         f = fin;
         f[F_N] = 1'b1;
         f[F_H] = 1'b1;
         zres = 1'b0;
      end
      ALU_CCF, ALU_SCF: begin
         f[F_Z] = fin[F_Z];
         f[F_C] = (op == ALU_SCF) || !fin[F_C];
         zres = 1'b0;
      end
      ALU_RLC, ALU_RL, ALU_SL: begin
         r = {x[6:0], (op == ALU_RLC) ? x[7] : (op == ALU_RL) && fin[F_C]};
         f[F_C] = x[7];
         zres = (op == ALU_SL) || (size != ALU_SIZE_SPEC);
      end
      ALU_RRC, ALU_RR, ALU_SRA, ALU_SRL: begin
         r = {(op == ALU_RRC) ? x[0] : (op == ALU_RR) ? fin[F_C] : (op == ALU_SRA) && x[7],
              x[7:1]};
         f[F_C] = x[0];
         zres = (op == ALU_SRA) || (op == ALU_SRL) || (size != ALU_SIZE_SPEC);
      end
      ALU_PASS1, ALU_SET, ALU_RES: begin
         r = x;
         if (op == ALU_SET) r[y[5:3]] = 1'b1;
         if (op == ALU_RES) r[y[5:3]] = 1'b0;
         f = fin;
         zres = 1'b0;
      end
      ALU_PASSF: begin
         f = y[7:4];
         zres = 1'b0;
      end
      ALU_BIT: begin
         f[F_Z] = !x[y[5:3]];
         f[F_H] = 1'b1;
         f[F_C] = fin[F_C];
         zres = 1'b0;
      end
      ALU_SWAP: r = {x[3:0], x[7:4]};
      default: begin
         f = fin;
         zres = 1'b0;
      end
   endcase
   if (zres) f[F_Z] = (r == 8'h00);
   return {f, r};
endfunction

function automatic logic [19:0] model_op(alu_op_e op, alu_size_e size, logic [15:0] a,
                                         logic [15:0] b, logic [3:0] fin);
   logic [3:0]  f;
   logic [11:0] lo;
   int          c;
   int          s;
   if (size == ALU_SIZE_16 && (op == ALU_ADD || op == ALU_ADC)) begin
      // Word add, H out of bit 11, Z kept
      c = (op == ALU_ADC) ? int'(fin[F_C]) : 0;
      s = int'(a) + int'(b) + c;
      f = 4'd0;
      f[F_Z] = fin[F_Z];
      f[F_H] = int'(a[11:0]) + int'(b[11:0]) + c > 'hfff;
      f[F_C] = s > 'hffff;
      return {f, 16'(s)};
   end
   if (size == ALU_SIZE_16 && (op == ALU_INC || op == ALU_DEC))
      return {fin, (op == ALU_INC) ? a + 16'd1 : a - 16'd1};
   lo = model_byte(op, size, a[7:0], b[7:0], fin);
   return {lo[11:8], 8'h00, lo[7:0]};
endfunction

// ==== verif/tb_gb80_alu_top.sv ====
module tb_gb80_alu_top;
   timeunit 1ns;
   timeprecision 1ps;
   import gb80_pkg::*;

   // About 1200 bus transfers of 2 clocks each, with margin
   localparam int TIMEOUT_CYCLES = 6000;

   logic        clk;
   logic        arst_n;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [3:0]  adr;
   logic [7:0]  dat_w;
   logic [7:0]  dat_r;
   logic        ack;
   logic [31:0] lfsr;
   int          cycles = 0;
   int          checks;
   int          errors;

   `include "tb_alu_model.svh"

   gb80_alu_top i_dut (
      .clk    (clk),
      .arst_n (arst_n),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .dat_w  (dat_w),
      .dat_r  (dat_r),
      .ack    (ack)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d clocks, the DUT stopped answering", cycles);
         $display("Test failed");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [15:0] rand_bits(int n);
      logic [15:0] v;
      v = 16'd0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);   // One step per bit
         v = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [7:0] bcd(int v);
      return {4'(v / 10), 4'(v % 10)};
   endfunction

   task automatic cmp_byte(string name, logic [7:0] got, logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic cmp_word(string name, logic [15:0] got, logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic cmp_flags(string name, logic [3:0] got, logic [3:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic wait_ack;
      int waits;
      waits = 0;
      do begin
         @(posedge clk);
         #1;
         waits++;
      end while (ack !== 1'b1);
      if (waits != 1) begin
         errors++;
         $display("ack came %0d clocks after the cycle opened instead of 1", waits);
      end
   endtask

   task automatic release_bus;
      @(posedge clk);   // Write lands on this edge
      #1;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      if (ack !== 1'b0) begin
         errors++;
         $display("ack stayed high for more than one clock");
      end
   endtask

   task automatic write_reg(logic [3:0] a, logic [7:0] d);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = 1'b1;
      adr   = a;
      dat_w = d;
      wait_ack();
      release_bus();
   endtask

   task automatic read_reg(logic [3:0] a, output logic [7:0] d);
      cyc = 1'b1;
      stb = 1'b1;
      we  = 1'b0;
      adr = a;
      wait_ack();
      d = dat_r;
      release_bus();
   endtask

   task automatic load_operands(logic [15:0] a, logic [15:0] b);
      write_reg(REG_OPA_LO, a[7:0]);
      write_reg(REG_OPA_HI, a[15:8]);
      write_reg(REG_OPB_LO, b[7:0]);
      write_reg(REG_OPB_HI, b[15:8]);
   endtask

   // Polls STATUS until idle, counting busy reads
   task automatic wait_idle(output int busy_reads);
      logic [7:0] st;
      busy_reads = 0;
      read_reg(REG_STATUS, st);
      while (st[0]) begin
         busy_reads++;
         read_reg(REG_STATUS, st);
      end
   endtask

   task automatic start_and_wait(alu_op_e op, alu_size_e size, output int busy_reads);
      write_reg(REG_CTRL, {1'b1, size, op});
      wait_idle(busy_reads);
   endtask

   task automatic check_op(alu_op_e op, alu_size_e size, logic [15:0] a, logic [15:0] b,
                           logic [3:0] fin);
      logic [19:0] exp;
      logic [7:0]  lo;
      logic [7:0]  hi;
      logic [7:0]  fb;
      int          busy_reads;
      exp = model_op(op, size, a, b, fin);
      load_operands(a, b);
      write_reg(REG_FLAGS, {fin, 4'h0});
      start_and_wait(op, size, busy_reads);
      if (busy_reads == 0) begin
         errors++;
         $display("STATUS never read busy after starting %s", op.name());
      end
      read_reg(REG_RES_LO, lo);
      read_reg(REG_RES_HI, hi);
      read_reg(REG_FLAGS, fb);
      cmp_word($sformatf("result of %s", op.name()), {hi, lo}, exp[15:0]);
      cmp_flags($sformatf("flags of %s", op.name()), fb[7:4], exp[19:16]);
   endtask

   task automatic reset_values;
      logic [7:0] d;
      for (int a = 0; a < 9; a++) begin
         read_reg(4'(a), d);
         cmp_byte($sformatf("register %0d after reset", a), d, 8'h00);
      end
   endtask

   task automatic arith_8bit;
      alu_op_e ops [6] = '{ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_INC, ALU_DEC};
      check_op(ALU_ADD, ALU_SIZE_8, 16'h00ff, 16'h0001, 4'h0);   // Z, H and C together
      for (int i = 0; i < 40; i++)
         check_op(ops[i % 6], ALU_SIZE_8, rand_bits(16), rand_bits(16), 4'(rand_bits(4)));
   endtask

   task automatic logic_and_shifts;
      alu_op_e ops [11] = '{ALU_AND, ALU_OR, ALU_XOR, ALU_NOT, ALU_RLC, ALU_RL, ALU_RRC,
                            ALU_RR, ALU_SL, ALU_SRA, ALU_SRL};
      for (int i = 0; i < 22; i++)
         check_op(ops[i % 11], ALU_SIZE_8, rand_bits(16), rand_bits(16), 4'(rand_bits(4)));
      check_op(ALU_RLC, ALU_SIZE_8, 16'h0000, 16'h0000, 4'h0);
      check_op(ALU_RLC, ALU_SIZE_SPEC, 16'h0000, 16'h0000, 4'h0);   // Zero result, Z stays 0
      check_op(ALU_RR, ALU_SIZE_SPEC, 16'h0001, 16'h0000, 4'h0);
   endtask

   task automatic daa_after_add_sub;
      int         da;
      int         db;
      int         exp;
      logic [7:0] r;
      logic [7:0] fb;
      logic [3:0] ef;
      int         busy_reads;
      for (int i = 0; i < 8; i++) begin
         da = int'(rand_bits(7)) % 100;
         db = int'(rand_bits(7)) % 100;
         exp = (i % 2 == 0) ? da + db : da - db;
         load_operands({8'h00, bcd(da)}, {8'h00, bcd(db)});
         write_reg(REG_FLAGS, 8'h00);
         start_and_wait((i % 2 == 0) ? ALU_ADD : ALU_SUB, ALU_SIZE_8, busy_reads);
         read_reg(REG_RES_LO, r);
         write_reg(REG_OPA_LO, r);   // DAA on the raw result, flags left as they are
         start_and_wait(ALU_DAA, ALU_SIZE_8, busy_reads);
         read_reg(REG_RES_LO, r);
         read_reg(REG_FLAGS, fb);
         ef = 4'd0;
         ef[F_Z] = ((exp + 100) % 100 == 0);
         ef[F_N] = (i % 2 != 0);
         ef[F_C] = (exp > 99) || (exp < 0);
         cmp_byte("DAA result", r, bcd((exp + 100) % 100));
         cmp_flags("DAA flags", fb[7:4], ef);
      end
   endtask

   task automatic bit_ops_and_passthroughs;
      alu_op_e    ops [7] = '{ALU_BIT, ALU_SET, ALU_RES, ALU_SWAP, ALU_PASS0, ALU_PASS1,
                              ALU_PASSF};
      logic [7:0] fb;
      for (int i = 0; i < 14; i++)
         check_op(ops[i % 7], ALU_SIZE_8, rand_bits(16), rand_bits(16), 4'(rand_bits(4)));
      check_op(ALU_SWAP, ALU_SIZE_8, 16'h0000, 16'h0000, 4'h0);
      check_op(ALU_SWAP, ALU_SIZE_8, 16'h00f0, 16'h0000, 4'hf);
      check_op(ALU_CCF, ALU_SIZE_8, rand_bits(16), rand_bits(16), 4'b1001);
      check_op(ALU_CCF, ALU_SIZE_8, rand_bits(16), rand_bits(16), 4'b0110);
      check_op(ALU_SCF, ALU_SIZE_8, rand_bits(16), rand_bits(16), 4'b0000);
      write_reg(REG_FLAGS, 8'hff);
      read_reg(REG_FLAGS, fb);
      cmp_byte("FLAGS", fb, 8'hf0);   // Low nibble reads zero
   endtask

   task automatic wide_16bit;
      alu_op_e ops [4] = '{ALU_ADD, ALU_ADC, ALU_INC, ALU_DEC};
      check_op(ALU_ADD, ALU_SIZE_16, 16'h12f0, 16'h0e20, 4'b1000);   // Carry out of low byte
      check_op(ALU_ADD, ALU_SIZE_16, 16'hffff, 16'h0001, 4'b0000);
      check_op(ALU_INC, ALU_SIZE_16, 16'h00ff, rand_bits(16), 4'b1010);
      check_op(ALU_DEC, ALU_SIZE_16, 16'h0100, rand_bits(16), 4'b0101);
      for (int i = 0; i < 8; i++)
         check_op(ops[i % 4], ALU_SIZE_16, rand_bits(16), rand_bits(16), 4'(rand_bits(4)));
   endtask

   task automatic ignored_start;
      logic [19:0] exp;
      logic [7:0]  lo;
      logic [7:0]  hi;
      logic [7:0]  d;
      int          busy_reads;
      exp = model_op(ALU_ADD, ALU_SIZE_16, 16'h34ff, 16'h0001, 4'h0);
      load_operands(16'h34ff, 16'h0001);
      write_reg(REG_FLAGS, 8'h00);
      write_reg(REG_CTRL, {1'b1, ALU_SIZE_16, ALU_ADD});
      write_reg(REG_CTRL, {1'b1, ALU_SIZE_8, ALU_SWAP});   // Arrives during the high step
      wait_idle(busy_reads);
      read_reg(REG_RES_LO, lo);
      read_reg(REG_RES_HI, hi);
      read_reg(REG_FLAGS, d);
      cmp_word("result with ignored start", {hi, lo}, exp[15:0]);
      cmp_flags("flags with ignored start", d[7:4], exp[19:16]);
      read_reg(REG_CTRL, d);
      cmp_byte("CTRL", d, {1'b0, ALU_SIZE_16, ALU_ADD});
   endtask

   initial begin
      clk    = 1'b0;
      arst_n = 1'b0;
      cyc    = 1'b0;
      stb    = 1'b0;
      we     = 1'b0;
      adr    = 4'd0;
      dat_w  = 8'd0;
      lfsr   = 32'h42f7_b1ca;
      checks = 0;
      errors = 0;
      repeat (3) @(posedge clk);
      #1;
      arst_n = 1'b1;
      reset_values();
      arith_8bit();
      logic_and_shifts();
      daa_after_add_sub();
      bit_ops_and_passthroughs();
      wide_16bit();
      ignored_start();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== hdl/gb80_alu_top.sv ====
module gb80_alu_top (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       cyc,
   input  logic       stb,
   input  logic       we,
   input  logic [3:0] adr,
   input  logic [7:0] dat_w,
   output logic [7:0] dat_r,
   output logic       ack
);

   alu_if bus ();

   alu_regs u_regs (
      .clk    (clk),
      .arst_n (arst_n),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .dat_w  (dat_w),
      .dat_r  (dat_r),
      .ack    (ack),
      .bus    (bus.regs)
   );

   alu_seq u_seq (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (bus.seq)
   );

endmodule

// ==== hdl/alu_regs.sv ====
module alu_regs (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       cyc,
   input  logic       stb,
   input  logic       we,
   input  logic [3:0] adr,
   input  logic [7:0] dat_w,
   output logic [7:0] dat_r,
   output logic       ack,
   alu_if.regs        bus
);
   import gb80_pkg::*;

   logic [15:0] opa_q;
   logic [15:0] opb_q;
   logic [15:0] res_q;
   logic [7:0]  ctrl_q;
   logic [3:0]  flags_q;
   logic [7:0]  rd_data;
   logic        cyc_open;
   logic        wr;

   assign cyc_open = cyc & stb;
   assign wr       = ack & cyc_open & we;   // Writes land on the ack edge

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ack   <= 1'b0;
         dat_r <= 8'd0;
      end else begin
         ack <= cyc_open & ~ack;
         if (cyc_open & ~ack & ~we) dat_r <= rd_data;
      end
   end

   always_comb begin
      case (adr)
         REG_OPA_LO: rd_data = opa_q[7:0];
         REG_OPA_HI: rd_data = opa_q[15:8];
         REG_OPB_LO: rd_data = opb_q[7:0];
         REG_OPB_HI: rd_data = opb_q[15:8];
         REG_CTRL:   rd_data = ctrl_q;
         REG_FLAGS:  rd_data = {flags_q, 4'd0};   // GB F layout
         REG_RES_LO: rd_data = res_q[7:0];
         REG_RES_HI: rd_data = res_q[15:8];
         REG_STATUS: rd_data = {7'd0, bus.busy};
         default:    rd_data = 8'd0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         opa_q   <= 16'd0;
         opb_q   <= 16'd0;
         ctrl_q  <= 8'd0;
         flags_q <= 4'd0;
         res_q   <= 16'd0;
      end else begin
         if (wr) begin
            case (adr)
               REG_OPA_LO: opa_q[7:0]  <= dat_w;
               REG_OPA_HI: opa_q[15:8] <= dat_w;
               REG_OPB_LO: opb_q[7:0]  <= dat_w;
               REG_OPB_HI: opb_q[15:8] <= dat_w;
               REG_CTRL: begin
                  // Start bit self-clears
                  if (!bus.busy) ctrl_q <= {1'b0, dat_w[CTRL_START_BIT-1:0]};
               end
               REG_FLAGS:  flags_q <= dat_w[7:4];
               default: ;
            endcase
         end
         if (bus.done) begin
            res_q   <= bus.result;
            flags_q <= bus.flags_out;   // Overrides a FLAGS write
         end
      end
   end

   assign bus.start    = wr && (adr == REG_CTRL) && dat_w[CTRL_START_BIT] && !bus.busy;
   assign bus.opa      = opa_q;
   assign bus.opb      = opb_q;
   assign bus.op       = alu_op_e'(dat_w[CTRL_OP_LSB +: 5]);
   assign bus.size     = alu_size_e'(dat_w[CTRL_SIZE_LSB +: 2]);
   assign bus.flags_in = flags_q;

   a_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      ack |-> (cyc && stb));

endmodule

// ==== hdl/alu_seq.sv ====
module alu_seq (
   input  logic clk,
   input  logic arst_n,
   alu_if.seq   bus
);
   import gb80_pkg::*;

   typedef enum logic [1:0] {IDLE, STEP_LO, STEP_HI} state_e;

   state_e      state, state_nxt;
   logic [15:0] opa_q, opb_q;
   alu_op_e     op_q;
   alu_size_e   size_q;
   logic [3:0]  fin_q;
   logic [7:0]  lo_q;          // Low result byte between steps
   logic [3:0]  flags_lo_q;
   logic        two_step;
   logic        lo_wrap;

   logic [7:0]  alu_d0, alu_d1, alu_out;
   alu_op_e     alu_op;
   alu_size_e   alu_size;
   logic [3:0]  alu_fin, alu_fout;

   assign two_step = (size_q == ALU_SIZE_16) &&
                     (op_q inside {ALU_ADD, ALU_ADC, ALU_INC, ALU_DEC});
   // High byte of inc/dec moves only when the low byte wrapped
   assign lo_wrap = (op_q == ALU_INC) ? (opa_q[7:0] == 8'hff) : (opa_q[7:0] == 8'h00);

   always_comb begin
      alu_d1   = opa_q[7:0];
      alu_d0   = opb_q[7:0];
      alu_op   = op_q;
      alu_size = size_q;
      alu_fin  = fin_q;
      if (state == STEP_HI) begin
         alu_d1   = opa_q[15:8];
         alu_d0   = opb_q[15:8];
         alu_size = ALU_SIZE_16;
         if (op_q == ALU_ADD || op_q == ALU_ADC) begin
            alu_op  = ALU_ADC;       // Carry from the low step
            alu_fin = flags_lo_q;
         end else if (!lo_wrap) begin
            alu_op = ALU_PASS1;
         end
      end
   end

   gb80_alu u_alu (
      .data0     (alu_d0),
      .data1     (alu_d1),
      .op        (alu_op),
      .flags_in  (alu_fin),
      .size      (alu_size),
      .data_out  (alu_out),
      .flags_out (alu_fout)
   );

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:    if (bus.start) state_nxt = STEP_LO;
         STEP_LO: state_nxt = two_step ? STEP_HI : IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) state <= IDLE;
      else state <= state_nxt;
   end

   always_ff @(posedge clk) begin
      if (bus.start) begin
         opa_q  <= bus.opa;
         opb_q  <= bus.opb;
         op_q   <= bus.op;
         size_q <= bus.size;
         fin_q  <= bus.flags_in;
      end
      if (state == STEP_LO) begin
         lo_q       <= alu_out;
         flags_lo_q <= alu_fout;
      end
   end

   assign bus.busy      = (state != IDLE);
   assign bus.done      = (state == STEP_HI) || (state == STEP_LO && !two_step);
   assign bus.result    = (state == STEP_HI) ? {alu_out, lo_q} : {8'h00, alu_out};
   assign bus.flags_out = alu_fout;

   a_done_single: assert property (@(posedge clk) disable iff (!arst_n)
      bus.done |=> !bus.done);

   // Register block must hold off starts while an op runs
   a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
      bus.start |-> !bus.busy);

endmodule

// ==== hdl/gb80_alu.sv ====
module gb80_alu (
   input  logic                [7:0] data0,
   input  logic                [7:0] data1,
   input  gb80_pkg::alu_op_e         op,
   input  logic                [3:0] flags_in,
   input  gb80_pkg::alu_size_e       size,
   output logic                [7:0] data_out,
   output logic                [3:0] flags_out
);
   import gb80_pkg::*;

   logic [4:0] lo;
   logic [4:0] hi;
   logic [8:0] daa1;
   logic [8:0] daa2;
   logic       cin;
   logic [2:0] bit_idx;

   assign bit_idx = data0[5:3];

   always_comb begin
      data_out  = data0;
      flags_out = 4'd0;
      cin       = 1'b0;
      lo        = 5'd0;
      hi        = 5'd0;
      daa1      = 9'd0;
      daa2      = 9'd0;
      case (op)
         ALU_ADD, ALU_ADC: begin
            cin = (op == ALU_ADC) & flags_in[F_C];
            lo = {1'b0, data1[3:0]} + {1'b0, data0[3:0]} + {4'd0, cin};
            hi = {1'b0, data1[7:4]} + {1'b0, data0[7:4]} + {4'd0, lo[4]};
            data_out = {hi[3:0], lo[3:0]};
            flags_out[F_H] = lo[4];
            flags_out[F_C] = hi[4];
            case (size)
               ALU_SIZE_16:   flags_out[F_Z] = flags_in[F_Z];  // 16-bit add keeps Z
               ALU_SIZE_SPEC: flags_out[F_Z] = 1'b0;
               default:       flags_out[F_Z] = (data_out == 8'd0);
            endcase
         end
         ALU_SUB, ALU_SBC: begin
            cin = (op == ALU_SBC) & flags_in[F_C];
            // Bit 4 of each nibble result is the borrow
            lo = {1'b0, data1[3:0]} - {1'b0, data0[3:0]} - {4'd0, cin};
            hi = {1'b0, data1[7:4]} - {1'b0, data0[7:4]} - {4'd0, lo[4]};
            data_out = {hi[3:0], lo[3:0]};
            flags_out[F_N] = 1'b1;
            flags_out[F_H] = lo[4];
            flags_out[F_C] = hi[4];
            flags_out[F_Z] = (data_out == 8'd0);
         end
         ALU_AND, ALU_OR, ALU_XOR: begin
            if (op == ALU_AND) begin
               data_out = data1 & data0;
               flags_out[F_H] = 1'b1;
            end else if (op == ALU_OR) begin
               data_out = data1 | data0;
            end else begin
               data_out = data1 ^ data0;
            end
            flags_out[F_Z] = (data_out == 8'd0);
         end
         ALU_INC, ALU_DEC: begin
            if (op == ALU_INC) begin
               lo = {1'b0, data1[3:0]} + 5'd1;
               hi = {1'b0, data1[7:4]} + {4'd0, lo[4]};
            end else begin
               lo = {1'b0, data1[3:0]} - 5'd1;
               hi = {1'b0, data1[7:4]} - {4'd0, lo[4]};
            end
            data_out = {hi[3:0], lo[3:0]};
            if (size == ALU_SIZE_16) begin
               flags_out = flags_in;   // 16-bit inc/dec leaves flags alone
            end else begin
               flags_out[F_N] = (op == ALU_DEC);
               flags_out[F_H] = lo[4];
               flags_out[F_C] = flags_in[F_C];
               flags_out[F_Z] = (data_out == 8'd0);
            end
         end
         ALU_DAA: begin
            if (!flags_in[F_N]) begin
               // Correction after an add
               daa1 = (flags_in[F_H] || data1[3:0] > 4'h9) ?
                      {1'b0, data1} + 9'h006 : {1'b0, data1};
               daa2 = (flags_in[F_C] || daa1 > 9'h09f) ? daa1 + 9'h060 : daa1;
            end else begin
               daa1 = flags_in[F_H] ? {1'b0, data1 - 8'h06} : {1'b0, data1};
               daa2 = flags_in[F_C] ? daa1 - 9'h060 : daa1;
            end
            data_out = daa2[7:0];
            flags_out[F_N] = flags_in[F_N];
            flags_out[F_C] = daa2[8] | flags_in[F_C];
            flags_out[F_Z] = (data_out == 8'd0);
         end
         ALU_NOT: begin
            data_out = ~data1;
            flags_out = flags_in;
            flags_out[F_N] = 1'b1;
            flags_out[F_H] = 1'b1;
         end
         ALU_CCF, ALU_SCF: begin
            flags_out[F_Z] = flags_in[F_Z];
            flags_out[F_C] = (op == ALU_SCF) | ~flags_in[F_C];
         end
         ALU_RLC, ALU_RL: begin
            data_out = {data1[6:0], (op == ALU_RLC) ? data1[7] : flags_in[F_C]};
            flags_out[F_C] = data1[7];
            flags_out[F_Z] = (size != ALU_SIZE_SPEC) && (data_out == 8'd0);
         end
         ALU_RRC, ALU_RR: begin
            data_out = {(op == ALU_RRC) ? data1[0] : flags_in[F_C], data1[7:1]};
            flags_out[F_C] = data1[0];
            flags_out[F_Z] = (size != ALU_SIZE_SPEC) && (data_out == 8'd0);
         end
         ALU_SL: begin
            data_out = {data1[6:0], 1'b0};
            flags_out[F_C] = data1[7];
            flags_out[F_Z] = (data_out == 8'd0);
         end
         ALU_SRA, ALU_SRL: begin
            data_out = {(op == ALU_SRA) & data1[7], data1[7:1]};  // SRA keeps sign
            flags_out[F_C] = data1[0];
            flags_out[F_Z] = (data_out == 8'd0);
         end
         ALU_PASS1: begin
            data_out = data1;
            flags_out = flags_in;
         end
         ALU_PASSF: flags_out = data0[7:4];
         ALU_BIT: begin
            flags_out[F_Z] = ~data1[bit_idx];
            flags_out[F_H] = 1'b1;
            flags_out[F_C] = flags_in[F_C];
         end
         ALU_SET, ALU_RES: begin
            data_out = data1;
            data_out[bit_idx] = (op == ALU_SET);
            flags_out = flags_in;
         end
         ALU_SWAP: begin
            data_out = {data1[3:0], data1[7:4]};
            flags_out[F_Z] = (data_out == 8'd0);   // From the swapped value
         end
         default: flags_out = flags_in;   // PASS0 and unused codes
      endcase
   end

endmodule

// ==== hdl/alu_if.sv ====
interface alu_if;
   import gb80_pkg::*;

   logic        start;      // One clock, only while idle
   logic [15:0] opa;
   logic [15:0] opb;
   alu_op_e     op;
   alu_size_e   size;
   logic [3:0]  flags_in;

   logic        busy;
   logic        done;       // One clock, result valid
   logic [15:0] result;
   logic [3:0]  flags_out;

   modport regs (
      output start, opa, opb, op, size, flags_in,
      input  busy, done, result, flags_out
   );

   modport seq (
      input  start, opa, opb, op, size, flags_in,
      output busy, done, result, flags_out
   );

endinterface

// ==== hdl/gb80_pkg.sv ====
package gb80_pkg;

   // ALU opcodes, 27..31 fall through to PASS0
   typedef enum logic [4:0] {
      ALU_ADD,
      ALU_ADC,
      ALU_SUB,
      ALU_SBC,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_INC,
      ALU_DEC,
      ALU_DAA,
      ALU_NOT,
      ALU_CCF,
      ALU_SCF,
      ALU_RLC,
      ALU_RL,
      ALU_RRC,
      ALU_RR,
      ALU_SL,
      ALU_SRA,
      ALU_SRL,
      ALU_PASS0,
      ALU_PASS1,
      ALU_PASSF,
      ALU_BIT,
      ALU_SET,
      ALU_RES,
      ALU_SWAP
   } alu_op_e;

   typedef enum logic [1:0] {
      ALU_SIZE_8,
      ALU_SIZE_16,
      ALU_SIZE_SPEC   // Z forced low on ADD and rotates
   } alu_size_e;

   // Flag nibble, ZNHC
   localparam int F_Z = 3;
   localparam int F_N = 2;
   localparam int F_H = 1;
   localparam int F_C = 0;

   // Wishbone word addresses
   localparam logic [3:0] REG_OPA_LO = 4'd0;
   localparam logic [3:0] REG_OPA_HI = 4'd1;
   localparam logic [3:0] REG_OPB_LO = 4'd2;
   localparam logic [3:0] REG_OPB_HI = 4'd3;
   localparam logic [3:0] REG_CTRL   = 4'd4;
   localparam logic [3:0] REG_FLAGS  = 4'd5;
   localparam logic [3:0] REG_RES_LO = 4'd6;
   localparam logic [3:0] REG_RES_HI = 4'd7;
   localparam logic [3:0] REG_STATUS = 4'd8;

   // Control byte is {start, size[1:0], op[4:0]}
   localparam int CTRL_START_BIT = 7;
   localparam int CTRL_SIZE_LSB  = 5;
   localparam int CTRL_OP_LSB    = 0;

endpackage
